// File: hdl/encap_pkg.sv
/*
 * Encapsulation port shared definitions.
 * Beat and header layouts, register offsets and the PIO word views.
 */
`default_nettype none

package encap_pkg;

    localparam int data_nbits = 32;
    localparam int keep_nbits = 4;
    localparam int pio_nbits  = 32;
    localparam int hdr_words  = 4;

    localparam logic [15:0] vlan_tpid = 16'h8100;

    // Offsets inside the register block.
    typedef enum logic [15:0] {
        mac_da_hi = 16'd0,
        mac_da_lo = 16'd1,
        mac_sa_hi = 16'd2,
        mac_sa_lo = 16'd3,
        vlan      = 16'd4,
        ctrl      = 16'd5
    } reg_offset_e;

    typedef struct packed {
        logic [data_nbits-1:0] data;
        logic [keep_nbits-1:0] keep;
        logic                  eop;
    } pkt_beat_t;

    typedef struct packed {
        pkt_beat_t beat;
        logic      sop;
    } pkt_in_t;

    typedef struct packed {
        logic [47:0] mac_da;
        logic [47:0] mac_sa;
        logic [15:0] vlan;
        logic        encap_en;
    } encap_hdr_t;

    typedef struct packed {
        logic [15:0] block;
        logic [15:0] offset;
    } pio_addr_t;

    // Address on the start cycle, write data on the cycle after.
    typedef union packed {
        pio_addr_t             addr;
        logic [pio_nbits-1:0]  data;
    } pio_word_u;

endpackage

`default_nettype wire

// File: hdl/encap_reg.sv
/*
 * Encapsulation register block.
 * Decodes the PIO bus and holds the outer MAC addresses, VLAN and enable.
 */
`timescale 1ns/1ps
`default_nettype none

module encap_reg #(
    parameter logic [15:0] BLOCK_ADDR = 16'h0040
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pio_start,
    input  logic                            pio_rw,
    input  encap_pkg::pio_word_u            pio_addr_wdata,
    output logic                            pio_ack,
    output logic                            pio_rvalid,
    output logic [encap_pkg::pio_nbits-1:0] pio_rdata,
    output encap_pkg::encap_hdr_t           hdr
);
    import encap_pkg::*;

    typedef enum logic {
        st_addr,
        st_wdata
    } state_e;

    state_e               state;
    reg_offset_e          wr_offset;
    logic [pio_nbits-1:0] rd_word;
    logic                 hit;

    assign hit = pio_start && (state == st_addr) &&
                 (pio_addr_wdata.addr.block == BLOCK_ADDR);

    // Read word with the unused bits left at zero.
    always_comb begin
        rd_word = '0;
        case (reg_offset_e'(pio_addr_wdata.addr.offset))
            mac_da_hi: rd_word[15:0] = hdr.mac_da[47:32];
            mac_da_lo: rd_word       = hdr.mac_da[31:0];
            mac_sa_hi: rd_word[15:0] = hdr.mac_sa[47:32];
            mac_sa_lo: rd_word       = hdr.mac_sa[31:0];
            vlan:      rd_word[15:0] = hdr.vlan;
            ctrl:      rd_word[0]    = hdr.encap_en;
            default:   rd_word       = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_addr;
            pio_ack    <= 1'b0;
            pio_rvalid <= 1'b0;
            hdr        <= '0;
        end else begin
            pio_ack    <= 1'b0;
            pio_rvalid <= 1'b0;
            case (state)
                st_addr: begin
                    if (hit) begin
                        if (pio_rw) begin
                            pio_rvalid <= 1'b1;
                        end else begin
                            state <= st_wdata;
                        end
                    end
                end
                st_wdata: begin
                    state   <= st_addr;
                    pio_ack <= 1'b1;
                    case (wr_offset)
                        mac_da_hi: hdr.mac_da[47:32] <= pio_addr_wdata.data[15:0];
                        mac_da_lo: hdr.mac_da[31:0]  <= pio_addr_wdata.data;
                        mac_sa_hi: hdr.mac_sa[47:32] <= pio_addr_wdata.data[15:0];
                        mac_sa_lo: hdr.mac_sa[31:0]  <= pio_addr_wdata.data;
                        vlan:      hdr.vlan          <= pio_addr_wdata.data[15:0];
                        ctrl:      hdr.encap_en      <= pio_addr_wdata.data[0];
                        default:   hdr               <= hdr;
                    endcase
                end
                default: state <= st_addr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            wr_offset <= reg_offset_e'(pio_addr_wdata.addr.offset);
            pio_rdata <= rd_word;
        end
    end

    a_ack_rvalid_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(pio_ack && pio_rvalid)
    ) else $error("pio_ack and pio_rvalid high together");

endmodule

`default_nettype wire

// File: hdl/encap_ingress.sv
/*
 * Inbound beat capture.
 * Registers accepted beats, tracks FIFO credits and drives port_bp.
 */
`timescale 1ns/1ps
`default_nettype none

module encap_ingress #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  encap_pkg::pkt_in_t    in_beat,
    output logic                  port_bp,
    output logic                  push,
    output encap_pkg::pkt_beat_t  push_beat,
    input  logic                  credit_return
);

    localparam int credit_nbits = $clog2(FIFO_DEPTH + 1);

    logic [credit_nbits-1:0] credits;
    logic [credit_nbits-1:0] credits_free;

    // Credits left once the pending push is spent.
    assign credits_free = credits - credit_nbits'(push);

    // Two free credits cover the beat the source may already be driving.
    assign port_bp = credits_free < credit_nbits'(2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push    <= 1'b0;
            credits <= credit_nbits'(FIFO_DEPTH);
        end else begin
            push <= in_valid;
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Packet start is implied by the previous eop.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            push_beat <= in_beat.beat;
        end
    end

    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n) credits <= credit_nbits'(FIFO_DEPTH)
    ) else $error("credit count above FIFO depth");

    a_push_credit: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> (credits != '0)
    ) else $error("push with no credit left");

endmodule

`default_nettype wire

// File: hdl/encap_fifo.sv
/*
 * Credit-controlled beat buffer.
 * Circular store with a registered head; returns one credit per pop.
 */
`timescale 1ns/1ps
`default_nettype none

module encap_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  encap_pkg::pkt_beat_t  push_beat,
    input  logic                  pop,
    output logic                  head_valid,
    output encap_pkg::pkt_beat_t  head_beat,
    output logic                  credit_return
);
    import encap_pkg::*;

    localparam int ptr_nbits   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int count_nbits = $clog2(FIFO_DEPTH + 1);

    pkt_beat_t              mem [FIFO_DEPTH];
    logic [ptr_nbits-1:0]   wr_ptr;
    logic [ptr_nbits-1:0]   rd_ptr;
    logic [ptr_nbits-1:0]   rd_ptr_next;
    logic [count_nbits-1:0] count;

    function automatic logic [ptr_nbits-1:0] ptr_inc(input logic [ptr_nbits-1:0] ptr);
        return (ptr == ptr_nbits'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            head_valid    <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr <= rd_ptr_next;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // A beat written this edge reaches the head one edge later.
            head_valid    <= (count - count_nbits'(pop)) != '0;
            credit_return <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
        head_beat <= mem[rd_ptr_next];
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> (count != count_nbits'(FIFO_DEPTH))
    ) else $error("push into a full buffer");

endmodule

`default_nettype wire

// File: hdl/encap_header_insert.sv
/*
 * Header inserter.
 * Prepends the outer MAC and VLAN words when enabled and streams the
 * payload out on the tx port with tready back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

module encap_header_insert (
    input  logic                             clk,
    input  logic                             rst_n,
    input  encap_pkg::encap_hdr_t            hdr,
    input  logic                             head_valid,
    input  encap_pkg::pkt_beat_t             head_beat,
    output logic                             pop,
    output logic                             tx_tvalid,
    output logic                             tx_tlast,
    output logic [encap_pkg::data_nbits-1:0] tx_tdata,
    output logic [encap_pkg::keep_nbits-1:0] tx_tkeep,
    input  logic                             tx_tready
);
    import encap_pkg::*;

    localparam int cnt_nbits = (hdr_words > 1) ? $clog2(hdr_words) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload
    } state_e;

    state_e                state;
    encap_hdr_t            hdr_q;
    logic [cnt_nbits-1:0]  word_cnt;
    logic [data_nbits-1:0] hdr_word;
    logic                  can_load;

    // Output register is free when empty or being taken.
    assign can_load = !tx_tvalid || tx_tready;
    assign pop      = (state == st_payload) && head_valid && can_load;

    always_comb begin
        case (word_cnt)
            cnt_nbits'(0): hdr_word = hdr_q.mac_da[47:16];
            cnt_nbits'(1): hdr_word = {hdr_q.mac_da[15:0], hdr_q.mac_sa[47:32]};
            cnt_nbits'(2): hdr_word = hdr_q.mac_sa[31:0];
            default:       hdr_word = {vlan_tpid, hdr_q.vlan};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            word_cnt  <= '0;
            tx_tvalid <= 1'b0;
        end else begin
            if (can_load) begin
                tx_tvalid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    // First beat of a packet is waiting at the head.
                    if (head_valid) begin
                        word_cnt <= '0;
                        state    <= hdr.encap_en ? st_header : st_payload;
                    end
                end
                st_header: begin
                    if (can_load) begin
                        tx_tvalid <= 1'b1;
                        word_cnt  <= word_cnt + 1'b1;
                        if (word_cnt == cnt_nbits'(hdr_words - 1)) begin
                            state <= st_payload;
                        end
                    end
                end
                st_payload: begin
                    if (pop) begin
                        tx_tvalid <= 1'b1;
                        if (head_beat.eop) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && head_valid) begin
            hdr_q <= hdr;
        end
        if (can_load) begin
            if (state == st_header) begin
                tx_tdata <= hdr_word;
                tx_tkeep <= '1;
                tx_tlast <= 1'b0;
            end else if (pop) begin
                tx_tdata <= head_beat.data;
                tx_tkeep <= head_beat.keep;
                tx_tlast <= head_beat.eop;
            end
        end
    end

    a_tx_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_tvalid && !tx_tready) |=>
            (tx_tvalid && $stable(tx_tdata) && $stable(tx_tkeep) && $stable(tx_tlast))
    ) else $error("tx beat changed while stalled");

endmodule

`default_nettype wire

// File: hdl/encap_top.sv
/*
 * Encapsulation port top level.
 * Register block, ingress, credit buffer and header inserter on one clock.
 */
`timescale 1ns/1ps
`default_nettype none

module encap_top #(
    parameter int          FIFO_DEPTH = 8,
    parameter logic [15:0] BLOCK_ADDR = 16'h0040
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pio_start,
    input  logic                             pio_rw,
    input  encap_pkg::pio_word_u             pio_addr_wdata,
    output logic                             pio_ack,
    output logic                             pio_rvalid,
    output logic [encap_pkg::pio_nbits-1:0]  pio_rdata,
    input  logic                             in_valid,
    input  encap_pkg::pkt_in_t               in_beat,
    output logic                             port_bp,
    output logic                             tx_tvalid,
    output logic                             tx_tlast,
    output logic [encap_pkg::data_nbits-1:0] tx_tdata,
    output logic [encap_pkg::keep_nbits-1:0] tx_tkeep,
    input  logic                             tx_tready
);
    import encap_pkg::*;

    encap_hdr_t hdr;
    logic       push;
    pkt_beat_t  push_beat;
    logic       credit_return;
    logic       head_valid;
    pkt_beat_t  head_beat;
    logic       pop;

    encap_reg #(
        .BLOCK_ADDR(BLOCK_ADDR)
    ) u_encap_reg (
        .clk(clk),
        .rst_n(rst_n),
        .pio_start(pio_start),
        .pio_rw(pio_rw),
        .pio_addr_wdata(pio_addr_wdata),
        .pio_ack(pio_ack),
        .pio_rvalid(pio_rvalid),
        .pio_rdata(pio_rdata),
        .hdr(hdr)
    );

    encap_ingress #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_encap_ingress (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_beat(in_beat),
        .port_bp(port_bp),
        .push(push),
        .push_beat(push_beat),
        .credit_return(credit_return)
    );

    encap_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_encap_fifo (
        .clk(clk),
        .rst_n(rst_n),
        .push(push),
        .push_beat(push_beat),
        .pop(pop),
        .head_valid(head_valid),
        .head_beat(head_beat),
        .credit_return(credit_return)
    );

    encap_header_insert u_encap_header_insert (
        .clk(clk),
        .rst_n(rst_n),
        .hdr(hdr),
        .head_valid(head_valid),
        .head_beat(head_beat),
        .pop(pop),
        .tx_tvalid(tx_tvalid),
        .tx_tlast(tx_tlast),
        .tx_tdata(tx_tdata),
        .tx_tkeep(tx_tkeep),
        .tx_tready(tx_tready)
    );

endmodule

`default_nettype wire

// File: test/encap_vectors.svh
/*
 * Encapsulation testbench vectors.
 * One row per packet with its register setting, payload shape and stall mode.
 */
`ifndef ENCAP_VECTORS_SVH
`define ENCAP_VECTORS_SVH

typedef struct packed {
    logic [95:0] name;
    logic [47:0] mac_da;
    logic [47:0] mac_sa;
    logic [15:0] vlan;
    logic        encap_en;
    logic [7:0]  len;
    logic [31:0] seed;
    logic [3:0]  last_keep;
    logic        long_stall;
} vector_t;

localparam int num_vectors = 8;

// Each row holds the name, mac_da, mac_sa, vlan, encap_en, payload beats, seed word,
// keep of the last beat and the long tready stall flag.
localparam vector_t vectors [num_vectors] = '{
    '{"en_basic", 48'h001122334455, 48'h66778899aabb, 16'h0064, 1'b1, 8'd4,
      32'h10000000, 4'hf, 1'b0},
    '{"en_short", 48'h001122334455, 48'h66778899aabb, 16'h0065, 1'b1, 8'd1,
      32'h20000000, 4'h1, 1'b0},
    '{"bypass", 48'h001122334455, 48'h66778899aabb, 16'h0065, 1'b0, 8'd5,
      32'h30000000, 4'h3, 1'b0},
    '{"bypass_one", 48'h001122334455, 48'h66778899aabb, 16'h0065, 1'b0, 8'd1,
      32'h40000000, 4'h7, 1'b0},
    '{"new_header", 48'h0a0b0c0d0e0f, 48'h102030405060, 16'h0123, 1'b1, 8'd3,
      32'h50000000, 4'hf, 1'b0},
    '{"stall_encap", 48'h02aa55cc33ff, 48'h1e2d3c4b5a69, 16'h0fff, 1'b1, 8'd40,
      32'h60000000, 4'h3, 1'b1},
    '{"stall_bypass", 48'h02aa55cc33ff, 48'h1e2d3c4b5a69, 16'h0fff, 1'b0, 8'd30,
      32'h70000000, 4'hf, 1'b1},
    '{"reenable", 48'h001122334455, 48'h66778899aabb, 16'h0064, 1'b1, 8'd6,
      32'h80000000, 4'h7, 1'b0}
};

`endif

// File: test/encap_tb.sv
/*
 * Encapsulation port testbench.
 * Programs the registers over PIO, streams packets through the port and
 * checks every tx beat against the expected header and payload words.
 */
`timescale 1ns/1ps
`default_nettype none

module encap_tb;
    import encap_pkg::*;

    `include "encap_vectors.svh"

    localparam logic [15:0] block_addr = 16'h0040;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  pio_start;
    logic                  pio_rw;
    pio_word_u             pio_addr_wdata;
    logic                  pio_ack;
    logic                  pio_rvalid;
    logic [pio_nbits-1:0]  pio_rdata;
    logic                  in_valid;
    pkt_in_t               in_beat;
    logic                  port_bp;
    logic                  tx_tvalid;
    logic                  tx_tlast;
    logic [data_nbits-1:0] tx_tdata;
    logic [keep_nbits-1:0] tx_tkeep;
    logic                  tx_tready;

    pkt_beat_t   exp_q[$];
    logic [95:0] test_name;
    logic        long_stall = 1'b0;
    logic        bp_seen = 1'b0;
    int          cycle_cnt = 0;
    int          timeout_cycles = 0;
    int          stall_phase = 0;

    encap_top #(.FIFO_DEPTH(8), .BLOCK_ADDR(block_addr)) dut_i (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        report_failure($sformatf("FAILED %0s %0s: expected %h, actual %h",
                                 test_name, what, expected, actual));
    endtask

    // Waits up to 4 cycles for the ack after the data word.
    task automatic pio_write(input logic [15:0] block, input logic [15:0] offset,
                             input logic [31:0] data, output logic acked);
        @(posedge clk);
        #2;
        pio_start = 1'b1;
        pio_rw = 1'b0;
        pio_addr_wdata.addr.block = block;
        pio_addr_wdata.addr.offset = offset;
        @(posedge clk);
        #2;
        pio_start = 1'b0;
        pio_addr_wdata.data = data;
        acked = 1'b0;
        for (int n = 0; n < 4 && !acked; n++) begin
            @(negedge clk);
            acked = pio_ack;
        end
    endtask

    task automatic pio_read(input logic [15:0] block, input logic [15:0] offset,
                            output logic got, output logic [31:0] data);
        @(posedge clk);
        #2;
        pio_start = 1'b1;
        pio_rw = 1'b1;
        pio_addr_wdata.addr.block = block;
        pio_addr_wdata.addr.offset = offset;
        @(posedge clk);
        #2;
        pio_start = 1'b0;
        got = 1'b0;
        data = '0;
        for (int n = 0; n < 4 && !got; n++) begin
            @(negedge clk);
            if (pio_rvalid) begin
                got = 1'b1;
                data = pio_rdata;
            end
        end
    endtask

    function automatic logic [31:0] payload_word(input logic [31:0] seed, input int idx);
        return seed + 32'(idx) * 32'h0101_0101;
    endfunction

    // Upper bits of the narrow registers are written as junk and must read as zero.
    task automatic program_registers(input vector_t v);
        logic [31:0] wr_val [6];
        logic [31:0] rd_exp [6];
        logic        ok;
        logic [31:0] rdata;
        wr_val = '{{16'hdead, v.mac_da[47:32]}, v.mac_da[31:0], {16'hbeef, v.mac_sa[47:32]},
                   v.mac_sa[31:0], {16'hc0de, v.vlan}, {31'h2aaa_aaaa, v.encap_en}};
        rd_exp = '{{16'h0, v.mac_da[47:32]}, v.mac_da[31:0], {16'h0, v.mac_sa[47:32]},
                   v.mac_sa[31:0], {16'h0, v.vlan}, {31'h0, v.encap_en}};
        for (int k = 0; k < 6; k++) begin
            pio_write(block_addr, 16'(k), wr_val[k], ok);
            assert (ok) else report_failure($sformatf("Register write %0d got no ack", k));
        end
        for (int k = 0; k < 6; k++) begin
            pio_read(block_addr, 16'(k), ok, rdata);
            assert (ok) else report_failure($sformatf("Register read %0d got no rvalid", k));
            assert (rdata == rd_exp[k])
                else report_mismatch($sformatf("register %0d", k), 64'(rd_exp[k]), 64'(rdata));
        end
    endtask

    task automatic queue_expected(input vector_t v);
        if (v.encap_en) begin
            exp_q.push_back({v.mac_da[47:16], 4'hf, 1'b0});
            exp_q.push_back({v.mac_da[15:0], v.mac_sa[47:32], 4'hf, 1'b0});
            exp_q.push_back({v.mac_sa[31:0], 4'hf, 1'b0});
            exp_q.push_back({16'h8100, v.vlan, 4'hf, 1'b0});
        end
        for (int i = 0; i < int'(v.len); i++) begin
            exp_q.push_back({payload_word(v.seed, i),
                             (i == v.len - 1) ? v.last_keep : 4'hf, i == v.len - 1});
        end
    endtask

    task automatic send_packet(input vector_t v);
        pkt_in_t beat;
        for (int i = 0; i < int'(v.len); i++) begin
            beat.beat.data = payload_word(v.seed, i);
            beat.beat.keep = (i == v.len - 1) ? v.last_keep : 4'hf;
            beat.beat.eop = (i == v.len - 1);
            beat.sop = (i == 0);
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #2;
                in_valid = 1'b0;
            end
            // A beat goes out only after port_bp was seen low before the edge.
            @(negedge clk);
            while (port_bp) begin
                @(posedge clk);
                #2;
                in_valid = 1'b0;
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            in_valid = 1'b1;
            in_beat = beat;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // Long mode holds tready low for 24 of every 32 cycles.
    always @(posedge clk) begin
        #2;
        stall_phase = (stall_phase + 1) % 32;
        if (long_stall && stall_phase < 24) begin
            tx_tready = 1'b0;
        end else begin
            tx_tready = ($urandom % 4) != 0;
        end
    end

    always @(negedge clk) begin : tx_sink
        pkt_beat_t expected;
        pkt_beat_t actual;
        if (port_bp === 1'b1) begin
            bp_seen = 1'b1;
        end
        if (rst_n === 1'b1 && tx_tvalid && tx_tready) begin
            assert (exp_q.size() != 0) else report_failure("A tx beat arrived with none expected");
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                actual.data = tx_tdata;
                actual.keep = tx_tkeep;
                actual.eop = tx_tlast;
                assert (actual == expected)
                    else report_mismatch("tx beat", 64'(expected), 64'(actual));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_cycles != 0 && cycle_cnt > timeout_cycles) begin
            report_failure($sformatf("The run timed out after %0d cycles", cycle_cnt));
        end
    end

    initial begin : main
        logic        ok;
        logic [31:0] rdata;
        vector_t     v;
        void'($urandom(48));
        timeout_cycles = 200;
        for (int i = 0; i < num_vectors; i++) begin
            timeout_cycles += 40 * (int'(vectors[i].len) + (vectors[i].encap_en ? hdr_words : 0));
        end
        rst_n = 1'b0;
        pio_start = 1'b0;
        pio_rw = 1'b0;
        pio_addr_wdata = '0;
        in_valid = 1'b0;
        in_beat = '0;
        tx_tready = 1'b0;
        test_name = "foreign_blk";
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        pio_write(block_addr + 16'h1, ctrl, 32'h1, ok);
        assert (!ok) else report_failure("A write to a foreign block select was acknowledged");
        pio_read(block_addr + 16'h1, ctrl, ok, rdata);
        assert (!ok) else report_failure("A read from a foreign block select returned data");
        pio_read(block_addr, ctrl, ok, rdata);
        assert (ok && rdata == 32'h0) else report_mismatch("ctrl", 64'h0, 64'(rdata));
        for (int i = 0; i < num_vectors; i++) begin
            v = vectors[i];
            test_name = v.name;
            program_registers(v);
            queue_expected(v);
            bp_seen = 1'b0;
            long_stall = v.long_stall;
            send_packet(v);
            while (exp_q.size() != 0) begin
                @(negedge clk);
            end
            long_stall = 1'b0;
            assert (!v.long_stall || bp_seen)
                else report_failure("port_bp never rose during long tready stalls");
        end
        repeat (10) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
hdl/encap_pkg.sv
hdl/encap_reg.sv
hdl/encap_ingress.sv
hdl/encap_fifo.sv
hdl/encap_header_insert.sv
hdl/encap_top.sv
test/encap_tb.sv
